// ==== hdl/video_pkg.sv ====
// video subsystem package: display modes, memory word union, geometry types, palette nibbles
package video_pkg;

	// display modes
	typedef enum logic [1:0] {
		mode_zx = 2'h0,
		mode_hc = 2'h1,
		mode_xc = 2'h2,
		mode_tx = 2'h3
	} render_mode_t;

	// zx view, attributes in the upper half
	typedef struct packed {
		logic [15:0] atr;
		logic [15:0] gfx;
	} zx_word_t;

	// one memory word as seen by each renderer mode
	typedef union packed {
		zx_word_t         zx;
		logic [7:0][3:0]  hc;
		logic [3:0][7:0]  xc;
	} vram_word_t;

	// word address into video memory
	typedef logic [9:0] vram_addr_t;

	// output pixel
	typedef logic [7:0] pixel_t;

	// raster positions
	typedef logic [9:0] hpos_t;
	typedef logic [9:0] line_t;

	// upper palette nibbles
	localparam logic [3:0] zx_pal = 4'hF;
	localparam logic [3:0] hc_pal = 4'hE;

	// border uses the same upper nibble as zx
	localparam logic [3:0] bdr_pal = 4'hF;

endpackage

// ==== hdl/vram_if.sv ====
// memory requester port interface with requester and arbiter modports
`timescale 1ns/100ps

interface vram_if;

	import video_pkg::*;

	logic       req;
	logic       we;
	vram_addr_t addr;
	vram_word_t wdata;
	logic       gnt;
	// valid the cycle after gnt on a read
	vram_word_t rdata;

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

// ==== hdl/video_ram.sv ====
// single-port video memory with registered read
`timescale 1ns/100ps

module video_ram #(
	parameter int mem_words = 1024
) (
	input  logic                  clk,
	input  logic                  en,
	input  logic                  we,
	input  video_pkg::vram_addr_t addr,
	input  video_pkg::vram_word_t wdata,
	output video_pkg::vram_word_t rdata
);

	import video_pkg::*;

	vram_word_t mem [mem_words];

	// write on en+we, otherwise read with one clock latency
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== hdl/vram_arbiter.sv ====
// fixed-priority memory arbiter, video port ahead of host port
`timescale 1ns/100ps

module vram_arbiter (
	input  logic                  clk,
	input  logic                  arst_n,
	vram_if.arbiter               video,
	vram_if.arbiter               host,
	output logic                  ram_en,
	output logic                  ram_we,
	output video_pkg::vram_addr_t ram_addr,
	output video_pkg::vram_word_t ram_wdata,
	input  video_pkg::vram_word_t ram_rdata
);

	import video_pkg::*;

	logic       rd_video;
	logic       rd_host;
	vram_word_t video_hold;
	vram_word_t host_hold;

	// video always wins, host only when video is idle
	assign video.gnt = video.req;
	assign host.gnt  = host.req & ~video.req;

	assign ram_en    = video.gnt | host.gnt;
	assign ram_we    = video.gnt ? video.we : host.we & host.gnt;
	assign ram_addr  = video.gnt ? video.addr : host.addr;
	assign ram_wdata = video.gnt ? video.wdata : host.wdata;

	// remember who owns the read data coming next cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_video <= 1'b0;
			rd_host  <= 1'b0;
		end else begin
			rd_video <= video.gnt & ~video.we;
			rd_host  <= host.gnt & ~host.we;
		end
	end

	// keep the last read word for a port that is not being served
	always_ff @(posedge clk) begin
		if (rd_video) begin
			video_hold <= ram_rdata;
		end
		if (rd_host) begin
			host_hold <= ram_rdata;
		end
	end

	assign video.rdata = rd_video ? ram_rdata : video_hold;
	assign host.rdata  = rd_host ? ram_rdata : host_hold;

endmodule

// ==== hdl/video_sync.sv ====
// pixel strobe divider and raster counters with line start, pixel start, active flag and syncs
`timescale 1ns/100ps

module video_sync #(
	parameter int h_active = 64,
	parameter int h_total  = 96,
	parameter int v_active = 8,
	parameter int v_total  = 12
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             hires,
	output logic             pix_stb,
	output logic             pix_start,
	output logic             hvpix,
	output logic             line_start,
	output logic             hsync,
	output logic             vsync,
	output video_pkg::line_t line
);

	import video_pkg::*;

	// pixel start sits one strobe before the first shown pixel,
	// the last pixel lands on the final column of the line
	localparam int px_start = h_total - h_active - 1;
	localparam int hs_beg   = 4;
	localparam int hs_end   = 12;
	localparam int vs_beg   = v_active + 1;
	localparam int vs_end   = v_active + 3;

	logic [1:0] div;
	hpos_t      hcnt;
	line_t      vcnt;
	logic       h_last;
	logic       v_last;
	logic       h_act;
	logic       v_act;

	// 1 of 2 clocks in hires, 1 of 4 in lores
	assign pix_stb = hires ? div[0] : &div;

	assign h_last = hcnt == hpos_t'(h_total - 1);
	assign v_last = vcnt == line_t'(v_total - 1);
	assign v_act  = vcnt < line_t'(v_active);
	assign h_act  = hcnt >= hpos_t'(px_start) && hcnt < hpos_t'(px_start + h_active);

	assign pix_start  = pix_stb & v_act & (hcnt == hpos_t'(px_start));
	assign line_start = pix_stb & v_act & (hcnt == '0);
	assign line       = vcnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div <= '0;
		end else begin
			div <= div + 2'd1;
		end
	end

	// counters and registered flags move on the strobe only
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hcnt  <= '0;
			vcnt  <= '0;
			hvpix <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else if (pix_stb) begin
			hcnt <= h_last ? '0 : hcnt + hpos_t'(1);
			if (h_last) begin
				vcnt <= v_last ? '0 : vcnt + line_t'(1);
			end
			// delayed by one strobe against the pixel counter
			hvpix <= v_act & h_act;
			hsync <= hcnt >= hpos_t'(hs_beg) && hcnt < hpos_t'(hs_end);
			vsync <= vcnt >= line_t'(vs_beg) && vcnt < line_t'(vs_end);
		end
	end

endmodule

// ==== hdl/video_fetch.sv ====
// line address generator with a one-word prefetch buffer for the renderer
`timescale 1ns/100ps

module video_fetch #(
	parameter int h_active = 64
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  video_pkg::render_mode_t render_mode,
	input  logic                    line_start,
	input  video_pkg::line_t        line,
	input  logic                    fetch,
	vram_if.requester               mem,
	output video_pkg::vram_word_t   word
);

	import video_pkg::*;

	vram_addr_t wpl;
	vram_addr_t addr;
	logic       req;
	logic       cap;

	// words per line, from pixels per word of each mode
	always_comb begin
		case (render_mode)
			mode_hc: wpl = vram_addr_t'(h_active / 8);
			mode_xc: wpl = vram_addr_t'(h_active / 4);
			default: wpl = vram_addr_t'(h_active / 16);
		endcase
	end

	// read only port
	assign mem.req   = req;
	assign mem.we    = 1'b0;
	assign mem.addr  = addr;
	assign mem.wdata = '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req  <= 1'b0;
			cap  <= 1'b0;
			addr <= '0;
		end else begin
			cap <= req & mem.gnt;
			if (line_start) begin
				addr <= vram_addr_t'(line * wpl);
				req  <= 1'b1;
			end else if (fetch) begin
				// renderer took the buffer, go for the next one
				addr <= addr + vram_addr_t'(1);
				req  <= 1'b1;
			end else if (mem.gnt) begin
				req <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cap) begin
			word <= mem.rdata;
		end
	end

endmodule

// ==== hdl/video_render.sv ====
// pixel renderer: pixel counter, word latch, per-mode decode and border mix
`timescale 1ns/100ps

module video_render (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    pix_stb,
	input  logic                    pix_start,
	input  logic                    hvpix,
	input  video_pkg::render_mode_t render_mode,
	input  logic [3:0]              border,
	input  video_pkg::vram_word_t   word,
	output logic                    fetch,
	output video_pkg::pixel_t       vdata_out
);

	import video_pkg::*;

	logic [3:0] cnt;
	logic       last;
	vram_word_t data;

	logic       zx_dot;
	logic [7:0] zx_attr;
	pixel_t     zx_pix;
	pixel_t     hc_pix;
	pixel_t     xc_pix;
	pixel_t     tx_pix;
	pixel_t     pix;

	// last pixel of the latched word
	always_comb begin
		case (render_mode)
			mode_hc: last = &cnt[2:0];
			mode_xc: last = &cnt[1:0];
			default: last = &cnt;
		endcase
	end

	// first word at line start, then one per word boundary
	assign fetch = pix_stb & (pix_start | (hvpix & last));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (pix_stb) begin
			cnt <= pix_start ? '0 : cnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch) begin
			data <= word;
		end
	end

	// zx: msb first in each gfx byte, low attr byte for the first 8 dots
	assign zx_dot  = data.zx.gfx[{cnt[3], ~cnt[2:0]}];
	assign zx_attr = cnt[3] ? data.zx.atr[15:8] : data.zx.atr[7:0];
	assign zx_pix  = {zx_pal, zx_attr[6], zx_dot ? zx_attr[2:0] : zx_attr[5:3]};

	// 16c: high nibble of each byte goes first
	assign hc_pix = {hc_pal, data.hc[{cnt[2:1], ~cnt[0]}]};

	// 256c: low byte first
	assign xc_pix = data.xc[cnt[1:0]];

	// text shares the zx dot path, fg in low nibble
	assign tx_pix = {hc_pal, zx_dot ? zx_attr[3:0] : zx_attr[7:4]};

	always_comb begin
		case (render_mode)
			mode_zx: pix = zx_pix;
			mode_hc: pix = hc_pix;
			mode_xc: pix = xc_pix;
			default: pix = tx_pix;
		endcase
	end

	assign vdata_out = hvpix ? pix : {bdr_pal, border};

endmodule

// ==== hdl/video_top.sv ====
// video subsystem top: memory, arbiter, sync, fetcher and renderer
`timescale 1ns/100ps

module video_top #(
	parameter int h_active  = 64,
	parameter int h_total   = 96,
	parameter int v_active  = 8,
	parameter int v_total   = 12,
	parameter int mem_words = 1024
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    hires,
	input  video_pkg::render_mode_t render_mode,
	input  logic [3:0]              border,
	input  logic                    host_req,
	input  logic                    host_we,
	input  video_pkg::vram_addr_t   host_addr,
	input  video_pkg::vram_word_t   host_wdata,
	output logic                    host_ack,
	output video_pkg::vram_word_t   host_rdata,
	output logic                    pix_stb,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    hvpix,
	output video_pkg::pixel_t       vdata_out
);

	vram_if video_if ();
	vram_if host_if ();

	logic                  ram_en;
	logic                  ram_we;
	video_pkg::vram_addr_t ram_addr;
	video_pkg::vram_word_t ram_wdata;
	video_pkg::vram_word_t ram_rdata;
	logic                  pix_start;
	logic                  line_start;
	video_pkg::line_t      line;
	logic                  fetch;
	video_pkg::vram_word_t word;

	// host side of the memory port
	assign host_if.req   = host_req;
	assign host_if.we    = host_we;
	assign host_if.addr  = host_addr;
	assign host_if.wdata = host_wdata;
	assign host_ack      = host_if.gnt;
	assign host_rdata    = host_if.rdata;

	video_ram #(.mem_words(mem_words)) video_ram_inst (
		.clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

	vram_arbiter vram_arbiter_inst (
		.clk(clk), .arst_n(arst_n), .video(video_if.arbiter), .host(host_if.arbiter),
		.ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

	video_sync #(
		.h_active(h_active), .h_total(h_total), .v_active(v_active), .v_total(v_total)
	) video_sync_inst (
		.clk(clk), .arst_n(arst_n), .hires(hires), .pix_stb(pix_stb),
		.pix_start(pix_start), .hvpix(hvpix), .line_start(line_start),
		.hsync(hsync), .vsync(vsync), .line(line)
	);

	video_fetch #(.h_active(h_active)) video_fetch_inst (
		.clk(clk), .arst_n(arst_n), .render_mode(render_mode), .line_start(line_start),
		.line(line), .fetch(fetch), .mem(video_if.requester), .word(word)
	);

	video_render video_render_inst (
		.clk(clk), .arst_n(arst_n), .pix_stb(pix_stb), .pix_start(pix_start),
		.hvpix(hvpix), .render_mode(render_mode), .border(border), .word(word),
		.fetch(fetch), .vdata_out(vdata_out)
	);

endmodule

// ==== sim/video_tb.sv ====
// video_top testbench with host load and readback, pixel reference, sync, border and contention
`timescale 1ns/100ps

module video_tb;

	import video_pkg::*;

	localparam int h_active  = 64;
	localparam int h_total   = 96;
	localparam int v_active  = 8;
	localparam int v_total   = 12;
	localparam int mem_words = 1024;
	// lores frames plus host load and readback plus margin
	localparam int max_frames  = 14;
	localparam int load_clocks = 2 * mem_words * 8;
	localparam int timeout_ns  = (max_frames * h_total * v_total * 4 + load_clocks + 4000) * 8;

	logic         clk = 1'b0;
	logic         arst_n;
	logic         hires;
	render_mode_t render_mode;
	logic [3:0]   border;
	logic         host_req;
	logic         host_we;
	vram_addr_t   host_addr;
	vram_word_t   host_wdata;
	logic         host_ack;
	vram_word_t   host_rdata;
	logic         pix_stb;
	logic         hsync;
	logic         vsync;
	logic         hvpix;
	pixel_t       vdata_out;

	vram_word_t   image [mem_words];
	logic [31:0]  rng = 32'h1466;
	logic         check_en;
	logic         vsync_q;
	logic         hsync_q;
	int           frames;
	int           line_no;
	int           pix_no;
	int           pix_checks;
	int           hs_gap;
	int           vs_gap;
	logic         hs_seen;
	logic         vs_seen;
	int           stb_gap;
	logic         stb_seen;
	logic         stb_hires;

	video_top video_top_inst (
		.clk(clk), .arst_n(arst_n), .hires(hires), .render_mode(render_mode),
		.border(border), .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
		.pix_stb(pix_stb), .hsync(hsync), .vsync(vsync), .hvpix(hvpix),
		.vdata_out(vdata_out)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// expected pixel n of an active line
	function automatic pixel_t ref_pixel(input render_mode_t mode, input int line, input int n);
		int          ppw;
		int          k;
		logic [31:0] w;
		logic [7:0]  g;
		logic [7:0]  a;
		logic        dot;
		case (mode)
			mode_hc: ppw = 8;
			mode_xc: ppw = 4;
			default: ppw = 16;
		endcase
		w = image[line * (h_active / ppw) + n / ppw];
		k = n % ppw;
		case (mode)
			// high nibble of each byte shown first
			mode_hc: begin
				g = w[8 * (k / 2) +: 8];
				return {hc_pal, (k % 2 == 0) ? g[7:4] : g[3:0]};
			end
			mode_xc: return w[8 * k +: 8];
			default: begin
				g   = (k < 8) ? w[7:0] : w[15:8];
				a   = (k < 8) ? w[23:16] : w[31:24];
				dot = g[7 - (k % 8)];
				if (mode == mode_zx) begin
					return {zx_pal, a[6], dot ? a[2:0] : a[5:3]};
				end else begin
					return {hc_pal, dot ? a[3:0] : a[7:4]};
				end
			end
		endcase
	endfunction

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			report_fail($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
		end
	endtask

	task automatic check_word(input string name, input vram_word_t got, input vram_word_t exp);
		if (got !== exp) begin
			report_fail($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_fail($sformatf("mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
		end
	endtask

	// one host request held until acknowledged
	task automatic host_access(input logic we, input vram_addr_t a, input vram_word_t d,
			output vram_word_t q);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		host_req   = 1'b1;
		host_we    = we;
		host_addr  = a;
		host_wdata = d;
		@(negedge clk);
		while (!host_ack) begin
			waited++;
			if (waited > 1000) begin
				report_fail($sformatf("host request to address %0d was never acknowledged", a));
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		host_req = 1'b0;
		@(negedge clk);
		q = host_rdata;
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames + n;
		while (frames < target) begin
			@(posedge clk);
		end
	endtask

	// new settings land in vertical blanking just after vsync rises
	task automatic start_frame(input render_mode_t mode, input logic hr);
		@(posedge clk);
		#1;
		render_mode = mode;
		hires       = hr;
		border      = border + 4'd3;
		check_en    = 1'b1;
	endtask

	// every strobe checked against the reference pixel or the border
	always @(negedge clk) begin
		if (arst_n && pix_stb) begin
			if (hvpix) begin
				check_bit("hsync", hsync, 1'b0);
				check_bit("vsync", vsync, 1'b0);
				if (check_en) begin
					check_pixel($sformatf("vdata_out line %0d pixel %0d", line_no, pix_no),
						vdata_out, ref_pixel(render_mode, line_no, pix_no));
					pix_checks++;
				end
				pix_no++;
				if (pix_no == h_active) begin
					pix_no = 0;
					line_no++;
				end
			end else begin
				check_pixel("vdata_out border", vdata_out, {4'hF, border});
				if (vsync) begin
					line_no = 0;
					pix_no  = 0;
				end
			end
			hs_gap++;
			vs_gap++;
			// one hsync pulse per line and one vsync pulse per frame
			if (hs_seen) begin
				check_bit("hsync rising edge", hsync & ~hsync_q, hs_gap == h_total);
			end
			if (vs_seen) begin
				check_bit("vsync rising edge", vsync & ~vsync_q, vs_gap == h_total * v_total);
			end
			if (hsync && !hsync_q) begin
				hs_gap  = 0;
				hs_seen = 1'b1;
			end
			if (vsync && !vsync_q) begin
				vs_gap  = 0;
				vs_seen = 1'b1;
				frames++;
			end
			hsync_q = hsync;
			vsync_q = vsync;
		end
	end

	// strobe spacing in clocks is left unchecked across a hires change
	always @(negedge clk) begin
		if (!arst_n) begin
			stb_gap  = 0;
			stb_seen = 1'b0;
		end else begin
			stb_gap++;
			if (stb_seen && hires == stb_hires) begin
				check_bit("pix_stb", pix_stb, stb_gap == (hires ? 2 : 4));
			end
			if (pix_stb) begin
				stb_gap   = 0;
				stb_seen  = 1'b1;
				stb_hires = hires;
			end
		end
	end

	initial begin
		#(timeout_ns);
		report_fail($sformatf("watchdog expired after %0d ns, the run did not finish", timeout_ns));
	end

	initial begin
		vram_word_t q;
		vram_addr_t a;
		logic       we;
		arst_n      = 1'b0;
		hires       = 1'b0;
		render_mode = mode_zx;
		border      = 4'h1;
		host_req    = 1'b0;
		host_we     = 1'b0;
		host_addr   = '0;
		host_wdata  = '0;
		check_en    = 1'b0;
		vsync_q     = 1'b0;
		hsync_q     = 1'b0;
		frames      = 0;
		line_no     = 0;
		pix_no      = 0;
		pix_checks  = 0;
		hs_gap      = 0;
		vs_gap      = 0;
		hs_seen     = 1'b0;
		vs_seen     = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			rng      = xorshift(rng);
			image[i] = rng;
		end
		repeat (16) @(posedge clk);
		#1;
		check_bit("hvpix", hvpix, 1'b0);
		check_bit("hsync", hsync, 1'b0);
		check_bit("vsync", vsync, 1'b0);
		arst_n = 1'b1;

		// load and read back the whole memory
		for (int i = 0; i < mem_words; i++) begin
			host_access(1'b1, vram_addr_t'(i), image[i], q);
		end
		for (int i = 0; i < mem_words; i++) begin
			host_access(1'b0, vram_addr_t'(i), '0, q);
			check_word($sformatf("host_rdata addr %0d", i), q, image[i]);
		end

		// every mode in lores then hires for one frame each
		for (int cfg = 0; cfg < 8; cfg++) begin
			wait_frames(1);
			start_frame(render_mode_t'(cfg % 4), cfg >= 4);
		end

		// host traffic above the displayed region while 256c hires runs
		wait_frames(1);
		start_frame(mode_xc, 1'b1);
		while (frames < 12) begin
			rng = xorshift(rng);
			a   = vram_addr_t'(256 + rng % 768);
			we  = rng[31];
			rng = xorshift(rng);
			host_access(we, a, rng, q);
			if (we) begin
				image[a] = rng;
			end else begin
				check_word($sformatf("host_rdata addr %0d", a), q, image[a]);
			end
		end
		wait_frames(1);

		if (pix_checks < 10 * h_active * v_active) begin
			report_fail($sformatf("only %0d active pixels were checked", pix_checks));
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// ==== src.f ====
hdl/video_pkg.sv
hdl/vram_if.sv
hdl/video_ram.sv
hdl/vram_arbiter.sv
hdl/video_sync.sv
hdl/video_fetch.sv
hdl/video_render.sv
hdl/video_top.sv
sim/video_tb.sv

// ==== Bender.yml ====
package:
  name: video

sources:
  - hdl/video_pkg.sv
  - hdl/vram_if.sv
  - hdl/video_ram.sv
  - hdl/vram_arbiter.sv
  - hdl/video_sync.sv
  - hdl/video_fetch.sv
  - hdl/video_render.sv
  - hdl/video_top.sv
  - target: simulation
    files:
      - sim/video_tb.sv
